//--- verilog/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Input ports of the mesh router
`define NOC_PORTS 5

// Virtual channels per link
`define NOC_VCS 2

// Flit body width in bits
`define NOC_DATA_WIDTH 16

// Grant FIFO entries for one queued packet per VC
`define NOC_GRANT_DEPTH 2

`endif

//--- verilog/noc_flit_pkg.sv
`include "noc_macros.svh"

package noc_flit_pkg;

  typedef enum logic {
    FLIT_BODY = 1'b0,
    FLIT_HEAD = 1'b1
  } flit_kind_t;

  // Header view filling the whole body width
  typedef struct packed {
    logic [3:0]                 dest_x;
    logic [3:0]                 dest_y;
    logic                       vc;      // VC of the packet
    logic [`NOC_DATA_WIDTH-10:0] length; // Flits after the head
  } flit_header_t;

  typedef logic [`NOC_DATA_WIDTH-1:0] flit_payload_t;

  // Same bits read as header on head flits and as data otherwise
  typedef union packed {
    flit_header_t  header;
    flit_payload_t payload;
  } flit_body_u;

  typedef struct packed {
    flit_kind_t kind;
    logic       tail;  // Last flit of the packet
    flit_body_u body;
  } flit_t;

endpackage

//--- verilog/noc_ctrl_pkg.sv
`include "noc_macros.svh"

package noc_ctrl_pkg;

  // One bit per input port
  typedef logic [`NOC_PORTS-1:0] port_vec_t;

  // One bit per virtual channel
  typedef logic [`NOC_VCS-1:0] vc_vec_t;

endpackage

//--- verilog/noc_round_robin_arbiter.sv
`timescale 1ns/100ps

module noc_round_robin_arbiter #(
  parameter int REQUESTS    = 2,
  parameter bit KEEP_RESULT = 1'b0
) (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic [REQUESTS-1:0] i_request,
  input  logic [REQUESTS-1:0] i_free,
  output logic [REQUESTS-1:0] o_grant
);

  logic [REQUESTS-1:0] mask_q;          // Requests above the last winner
  logic [REQUESTS-1:0] masked_request;
  logic [REQUESTS-1:0] masked_pick;
  logic [REQUESTS-1:0] plain_pick;
  logic [REQUESTS-1:0] new_grant;
  logic [REQUESTS-1:0] up_to_winner;
  logic [REQUESTS-1:0] grant_q;
  logic                busy_q;          // Grant held until freed

  assign masked_request = i_request & mask_q;

  // Lowest set bit of each vector
  assign masked_pick = masked_request & (~masked_request + 1'b1);
  assign plain_pick  = i_request & (~i_request + 1'b1);

  // Wrap to the bottom when nothing is left above the pointer
  assign new_grant = (|masked_request) ? masked_pick : plain_pick;

  assign o_grant = (KEEP_RESULT && busy_q) ? grant_q : new_grant;

  assign up_to_winner = (new_grant << 1) - 1'b1;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mask_q  <= '1;                    // Port 0 first after reset
      busy_q  <= 1'b0;
      grant_q <= '0;
    end else begin
      if (|new_grant && !busy_q) begin
        mask_q <= ~up_to_winner;        // Priority moves past the winner
      end
      busy_q  <= KEEP_RESULT && (|o_grant) && !(|(o_grant & i_free));
      grant_q <= o_grant;
    end
  end

endmodule

//--- verilog/noc_grant_fifo.sv
`timescale 1ns/100ps

module noc_grant_fifo #(
  parameter int WIDTH = 5,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty,
  output logic             o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_next;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push_ok;
  logic             pop_ok;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ok     = i_push & ~o_full;   // Push on full is dropped
  assign pop_ok      = i_pop & ~o_empty;
  assign rd_ptr_next = pop_ok ? next_ptr(rd_ptr) : rd_ptr;
  assign count_next  = count + CNT_W'(push_ok) - CNT_W'(pop_ok);

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      o_data  <= '0;
      o_empty <= 1'b1;
      o_full  <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      rd_ptr <= rd_ptr_next;
      count  <= count_next;
      if (push_ok && (count - CNT_W'(pop_ok)) == '0) begin
        o_data <= i_data;                   // New entry becomes the head
      end else if (pop_ok) begin
        o_data <= mem[rd_ptr_next];
      end
      o_empty <= (count_next == '0);
      o_full  <= (count_next == CNT_W'(DEPTH));
    end
  end

endmodule

//--- verilog/noc_input_status.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module noc_input_status (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  noc_ctrl_pkg::port_vec_t i_valid,
  input  noc_flit_pkg::flit_t     i_flit [`NOC_PORTS],
  input  noc_ctrl_pkg::port_vec_t i_accept,
  output noc_ctrl_pkg::vc_vec_t   o_start [`NOC_PORTS],
  output noc_ctrl_pkg::vc_vec_t   o_request [`NOC_PORTS],
  output noc_ctrl_pkg::vc_vec_t   o_end [`NOC_PORTS]
);

  for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_port
    logic is_head;
    logic packet_vc;
    logic vc_q;         // VC of the packet in progress

    assign is_head   = i_valid[p] && (i_flit[p].kind == noc_flit_pkg::FLIT_HEAD);
    assign packet_vc = is_head ? i_flit[p].body.header.vc : vc_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        vc_q <= 1'b0;
      end else if (is_head) begin
        vc_q <= i_flit[p].body.header.vc;
      end
    end

    for (genvar v = 0; v < `NOC_VCS; v++) begin : g_vc
      assign o_start[p][v]   = is_head && (packet_vc == 1'(v));
      assign o_request[p][v] = i_valid[p] && (packet_vc == 1'(v));
      assign o_end[p][v]     = i_valid[p] && i_accept[p] && i_flit[p].tail &&
                               (packet_vc == 1'(v));  // Tail leaving this cycle
    end
  end

endmodule

//--- verilog/noc_port_controller.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module noc_port_controller (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  noc_ctrl_pkg::vc_vec_t   i_vc_available,
  input  noc_ctrl_pkg::vc_vec_t   i_start [`NOC_PORTS],
  input  noc_ctrl_pkg::vc_vec_t   i_request [`NOC_PORTS],
  input  noc_ctrl_pkg::vc_vec_t   i_end [`NOC_PORTS],
  input  logic                    i_packet_done,
  output noc_ctrl_pkg::port_vec_t o_output_grant,
  output logic                    o_grant_valid
);

  noc_ctrl_pkg::port_vec_t start [`NOC_VCS];
  noc_ctrl_pkg::port_vec_t request [`NOC_VCS];
  noc_ctrl_pkg::port_vec_t port_end [`NOC_VCS];
  noc_ctrl_pkg::port_vec_t port_grant [`NOC_VCS];
  noc_ctrl_pkg::port_vec_t output_grant;
  noc_ctrl_pkg::vc_vec_t   vc_request;
  noc_ctrl_pkg::vc_vec_t   vc_grant;
  noc_ctrl_pkg::vc_vec_t   vc_end;
  noc_ctrl_pkg::vc_vec_t   vc_queued;     // VC already has a packet in the FIFO
  logic                    fifo_push;
  logic                    fifo_full;
  logic                    fifo_empty;

  // Regroup per VC
  for (genvar v = 0; v < `NOC_VCS; v++) begin : g_regroup
    for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_port
      assign start[v][p]    = i_start[p][v];
      assign request[v][p]  = i_request[p][v];
      assign port_end[v][p] = i_end[p][v];
    end
  end

  for (genvar v = 0; v < `NOC_VCS; v++) begin : g_port_arbitration
    noc_round_robin_arbiter #(
      .REQUESTS    (`NOC_PORTS),
      .KEEP_RESULT (1'b1)
    ) u_port_arbiter (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_request (start[v]),
      .i_free    (port_end[v]),
      .o_grant   (port_grant[v])
    );

    assign vc_request[v] = |(request[v] & port_grant[v]) & i_vc_available[v] &
                           ~vc_queued[v] & ~fifo_full;
    assign vc_end[v]     = |(port_end[v] & port_grant[v]);
  end

  noc_round_robin_arbiter #(
    .REQUESTS    (`NOC_VCS),
    .KEEP_RESULT (1'b0)
  ) u_vc_arbiter (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_request (vc_request),
    .i_free    (vc_end),
    .o_grant   (vc_grant)
  );

  always_comb begin
    output_grant = '0;
    for (int v = 0; v < `NOC_VCS; v++) begin
      if (vc_grant[v]) begin
        output_grant |= port_grant[v];    // VC grant is one-hot
      end
    end
  end

  assign fifo_push = |vc_grant;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      vc_queued <= '0;
    end else begin
      vc_queued <= (vc_queued & ~vc_end) | vc_grant;
    end
  end

  noc_grant_fifo #(
    .WIDTH (`NOC_PORTS),
    .DEPTH (`NOC_GRANT_DEPTH)
  ) u_grant_fifo (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_push  (fifo_push),
    .i_data  (output_grant),
    .i_pop   (i_packet_done),
    .o_data  (o_output_grant),
    .o_empty (fifo_empty),
    .o_full  (fifo_full)
  );

  assign o_grant_valid = ~fifo_empty;

endmodule

//--- verilog/noc_output_switch.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module noc_output_switch (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  noc_ctrl_pkg::port_vec_t i_output_grant,
  input  logic                    i_grant_valid,
  input  noc_ctrl_pkg::port_vec_t i_valid,
  input  noc_flit_pkg::flit_t     i_flit [`NOC_PORTS],
  output noc_ctrl_pkg::port_vec_t o_accept,
  output logic                    o_packet_done,
  output logic                    o_valid,
  output noc_flit_pkg::flit_t     o_flit,
  output logic                    o_vc
);

  noc_flit_pkg::flit_t sel_flit;
  logic                forward;

  // Flit of the port at the FIFO head
  always_comb begin
    sel_flit = '0;
    for (int p = 0; p < `NOC_PORTS; p++) begin
      if (i_output_grant[p]) begin
        sel_flit = i_flit[p];
      end
    end
  end

  assign o_accept      = {`NOC_PORTS{i_grant_valid}} & i_output_grant & i_valid;
  assign forward       = |o_accept;
  assign o_packet_done = forward && sel_flit.tail;    // Pops the grant FIFO

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
      o_vc    <= 1'b0;
    end else begin
      o_valid <= forward;
      if (forward && sel_flit.kind == noc_flit_pkg::FLIT_HEAD) begin
        o_vc <= sel_flit.body.header.vc;    // Kept for the body flits
      end
    end
  end

  always_ff @(posedge clk) begin
    if (forward) begin
      o_flit <= sel_flit;
    end
  end

endmodule

//--- verilog/noc_output_unit.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module noc_output_unit (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  noc_ctrl_pkg::port_vec_t i_valid,
  input  noc_flit_pkg::flit_t     i_flit [`NOC_PORTS],
  input  noc_ctrl_pkg::vc_vec_t   i_vc_available,
  output noc_ctrl_pkg::port_vec_t o_accept,
  output logic                    o_valid,
  output noc_flit_pkg::flit_t     o_flit,
  output logic                    o_vc
);

  noc_ctrl_pkg::vc_vec_t   start [`NOC_PORTS];
  noc_ctrl_pkg::vc_vec_t   request [`NOC_PORTS];
  noc_ctrl_pkg::vc_vec_t   packet_end [`NOC_PORTS];
  noc_ctrl_pkg::port_vec_t output_grant;
  logic                    grant_valid;
  logic                    packet_done;

  noc_input_status u_input_status (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_valid),
    .i_flit    (i_flit),
    .i_accept  (o_accept),
    .o_start   (start),
    .o_request (request),
    .o_end     (packet_end)
  );

  noc_port_controller u_port_controller (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_vc_available (i_vc_available),
    .i_start        (start),
    .i_request      (request),
    .i_end          (packet_end),
    .i_packet_done  (packet_done),
    .o_output_grant (output_grant),
    .o_grant_valid  (grant_valid)
  );

  noc_output_switch u_output_switch (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_output_grant (output_grant),
    .i_grant_valid  (grant_valid),
    .i_valid        (i_valid),
    .i_flit         (i_flit),
    .o_accept       (o_accept),
    .o_packet_done  (packet_done),
    .o_valid        (o_valid),
    .o_flit         (o_flit),
    .o_vc           (o_vc)
  );

endmodule

//--- bench/noc_output_unit_props.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module noc_output_unit_props (
  input logic                    clk,
  input logic                    i_rst_n,
  input noc_ctrl_pkg::port_vec_t port_grant [`NOC_VCS],
  input logic                    fifo_push,
  input logic                    fifo_full,
  input noc_ctrl_pkg::port_vec_t o_output_grant,
  input logic                    o_grant_valid
);

  for (genvar v = 0; v < `NOC_VCS; v++) begin : g_vc
    a_port_grant_onehot: assert property (
      @(posedge clk) disable iff (!i_rst_n) $onehot0(port_grant[v])
    ) else $error("port grant of VC %0d has more than one bit set", v);
  end

  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!i_rst_n) fifo_push |-> !fifo_full
  ) else $error("grant FIFO pushed while full");

  // The queued grant is the port mask of the accept strobe
  a_accept_onehot: assert property (
    @(posedge clk) disable iff (!i_rst_n) o_grant_valid |-> $onehot(o_output_grant)
  ) else $error("queued grant selects more than one port");

  a_quiet_in_reset: assert property (
    @(posedge clk) !i_rst_n |-> (!o_grant_valid && !fifo_full)
  ) else $error("grant FIFO not empty during reset");

endmodule

//--- bench/noc_output_unit_tb.sv
`timescale 1ns/100ps
`include "noc_macros.svh"

module noc_output_unit_tb;

  localparam int NUM_TESTS  = 5;
  localparam int CLK_PERIOD = 40;

  logic                    clk = 1'b0;
  logic                    i_rst_n = 1'b1;
  noc_ctrl_pkg::port_vec_t i_valid = '0;
  noc_flit_pkg::flit_t     i_flit [`NOC_PORTS] = '{default: '0};
  noc_ctrl_pkg::vc_vec_t   i_vc_available;
  noc_ctrl_pkg::port_vec_t o_accept;
  logic                    o_valid;
  noc_flit_pkg::flit_t     o_flit;
  logic                    o_vc;

  noc_flit_pkg::flit_t     in_q [`NOC_PORTS][$];   // Flits still held at each input
  noc_flit_pkg::flit_t     exp_q [`NOC_PORTS][$];  // Flits each port still owes
  noc_flit_pkg::flit_t     out_flit [$];
  logic                    out_vc [$];
  int                      out_cycle [$];
  int                      pkt_port [$];
  int                      pkt_vc [$];
  noc_ctrl_pkg::port_vec_t accepted = '0;
  logic [15:0]             lfsr = 16'd86;
  int                      cycle = 0;
  int                      total_flits;
  int                      checks;
  int                      errors;

  noc_output_unit i_noc_output_unit (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_valid        (i_valid),
    .i_flit         (i_flit),
    .i_vc_available (i_vc_available),
    .o_accept       (o_accept),
    .o_valid        (o_valid),
    .o_flit         (o_flit),
    .o_vc           (o_vc)
  );

  bind noc_port_controller noc_output_unit_props u_props (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .port_grant     (port_grant),
    .fifo_push      (fifo_push),
    .fifo_full      (fifo_full),
    .o_output_grant (o_output_grant),
    .o_grant_valid  (o_grant_valid)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
  end

  // Input buffers that show the next flit after an accept
  always @(posedge clk) begin
    #2;
    for (int p = 0; p < `NOC_PORTS; p++) begin
      if (accepted[p] && in_q[p].size() > 0) begin
        void'(in_q[p].pop_front());
      end
      i_valid[p] = (in_q[p].size() > 0);
      i_flit[p]  = i_valid[p] ? in_q[p][0] : '0;
    end
  end

  always @(negedge clk) begin
    accepted = o_accept;
    if (o_valid) begin
      out_flit.push_back(o_flit);
      out_vc.push_back(o_vc);
      out_cycle.push_back(cycle);
    end
  end

  // Fibonacci LFSR with taps for x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_bits(input int n);
    logic [15:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr  = {lfsr[14:0], fb};
      value = {value[14:0], fb};
    end
    return value;
  endfunction

  task automatic build_packet(input int port, input int vc, input int nbody, input int serial);
    noc_flit_pkg::flit_t f;
    f = '0;
    f.kind = noc_flit_pkg::FLIT_HEAD;
    f.tail = (nbody == 0);
    f.body.header.dest_x = 4'(port);   // Source port tag for the checker
    f.body.header.dest_y = 4'(serial);
    f.body.header.vc     = 1'(vc);
    f.body.header.length = 7'(nbody);
    in_q[port].push_back(f);
    exp_q[port].push_back(f);
    for (int i = 0; i < nbody; i++) begin
      f = '0;
      f.kind = noc_flit_pkg::FLIT_BODY;
      f.tail = (i == nbody - 1);
      f.body.payload = lfsr_bits(16);
      in_q[port].push_back(f);
      exp_q[port].push_back(f);
    end
    total_flits += nbody + 1;
  endtask

  task automatic start_test();
    out_flit.delete();
    out_vc.delete();
    out_cycle.delete();
    total_flits = 0;
    @(negedge clk);
  endtask

  task automatic wait_for_output(input int count);
    while (out_flit.size() < count) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    checks++;
    assert (out_flit.size() == count) else begin
      $display("error at %0t: %0d flits out, %0d expected", $time, out_flit.size(), count);
      errors++;
    end
  endtask

  // Splits the output into packets and matches each with its source port
  task automatic check_stream();
    int                  idx;
    int                  p;
    logic                done;
    logic                exp_vc;
    noc_flit_pkg::flit_t head;
    noc_flit_pkg::flit_t want;
    pkt_port.delete();
    pkt_vc.delete();
    idx = 0;
    while (idx < out_flit.size()) begin
      head = out_flit[idx];
      p    = int'(head.body.header.dest_x);
      checks++;
      assert (head.kind == noc_flit_pkg::FLIT_HEAD && p < `NOC_PORTS && exp_q[p].size() > 0)
      else begin
        $display("error at %0t: output flit %0d starts no expected packet", $time, idx);
        errors++;
        return;
      end
      exp_vc = exp_q[p][0].body.header.vc;    // VC of the packet the port sent
      pkt_port.push_back(p);
      pkt_vc.push_back(int'(exp_vc));
      done = 1'b0;
      while (!done) begin
        want = exp_q[p].pop_front();
        done = want.tail;
        checks++;
        assert (idx < out_flit.size() && out_flit[idx] == want &&
                out_vc[idx] == exp_vc) else begin
          $display("error at %0t: port %0d flit wrong at output %0d", $time, p, idx);
          errors++;
        end
        idx++;
      end
    end
    for (int q = 0; q < `NOC_PORTS; q++) begin
      checks++;
      assert (exp_q[q].size() == 0) else begin
        $display("error at %0t: port %0d lost %0d flits", $time, q, exp_q[q].size());
        errors++;
        exp_q[q].delete();
      end
    end
  endtask

  task automatic single_packet();
    int offer;
    start_test();
    build_packet(4, 1, 3, 1);
    offer = cycle + 1;               // Head is driven after the next edge
    wait_for_output(total_flits);
    checks++;
    assert (out_cycle[0] - offer == 2) else begin
      $display("error at %0t: head latency %0d cycles, 2 expected", $time, out_cycle[0] - offer);
      errors++;
    end
    check_stream();
  endtask

  task automatic same_vc_contention();
    start_test();
    for (int p = 0; p < `NOC_PORTS; p++) begin
      build_packet(p, 0, 2 + p % 2, 1);
    end
    wait_for_output(total_flits);
    check_stream();
    for (int i = 0; i < pkt_port.size(); i++) begin
      checks++;
      assert (pkt_port[i] == i) else begin
        $display("error at %0t: packet %0d came from port %0d", $time, i, pkt_port[i]);
        errors++;
      end
    end
  endtask

  task automatic two_vc_alternation();
    start_test();
    build_packet(1, 0, 3, 1);
    build_packet(1, 0, 2, 2);
    build_packet(2, 1, 2, 1);
    build_packet(2, 1, 3, 2);
    wait_for_output(total_flits);
    check_stream();
    for (int i = 1; i < pkt_vc.size(); i++) begin
      checks++;
      assert (pkt_vc[i] != pkt_vc[i - 1]) else begin
        $display("error at %0t: packets %0d and %0d both on VC %0d", $time, i - 1, i, pkt_vc[i]);
        errors++;
      end
    end
  endtask

  task automatic vc_backpressure();
    start_test();
    @(posedge clk);
    #2 i_vc_available = 2'b01;       // No credit on VC 1
    @(negedge clk);
    build_packet(3, 1, 2, 1);
    build_packet(0, 0, 2, 1);
    build_packet(0, 0, 1, 2);
    wait_for_output(5);
    for (int i = 0; i < out_vc.size(); i++) begin
      checks++;
      assert (out_vc[i] == 1'b0) else begin
        $display("error at %0t: VC 1 flit output without credit", $time);
        errors++;
      end
    end
    @(posedge clk);
    #2 i_vc_available = 2'b11;
    wait_for_output(total_flits);
    check_stream();
  endtask

  task automatic fifo_overflow();
    start_test();
    for (int s = 1; s <= 2; s++) begin
      for (int p = 0; p < `NOC_PORTS; p++) begin
        build_packet(p, p % 2, 1 + (p + s) % 3, s);
      end
    end
    wait_for_output(total_flits);
    check_stream();
    checks++;
    assert (pkt_port.size() == 2 * `NOC_PORTS) else begin
      $display("error at %0t: %0d packets out, %0d expected", $time, pkt_port.size(),
               2 * `NOC_PORTS);
      errors++;
    end
  endtask

  initial begin
    #(NUM_TESTS * 400 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 400);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    i_vc_available = '1;
    checks = 0;
    errors = 0;
    total_flits = 0;
    #1 i_rst_n = 1'b0;
    repeat (10) @(posedge clk);
    checks++;
    assert (!o_valid && o_accept == '0) else begin
      $display("error at %0t: outputs active during reset", $time);
      errors++;
    end
    #2 i_rst_n = 1'b1;
    single_packet();
    same_vc_contention();
    two_vc_alternation();
    vc_backpressure();
    fifo_overflow();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- noc_output_unit.f
+incdir+verilog
verilog/noc_flit_pkg.sv
verilog/noc_ctrl_pkg.sv
verilog/noc_round_robin_arbiter.sv
verilog/noc_grant_fifo.sv
verilog/noc_input_status.sv
verilog/noc_port_controller.sv
verilog/noc_output_switch.sv
verilog/noc_output_unit.sv
bench/noc_output_unit_props.sv
bench/noc_output_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module noc_output_unit_tb \
  -f noc_output_unit.f \
  -o sim_noc_output_unit

result=$(./obj_dir/sim_noc_output_unit 2>&1 || true)
echo "$result"
echo "$result" | grep -q ">>> PASS"
